// File: common/dec_settings.svh
`ifndef DEC_SETTINGS_SVH
`define DEC_SETTINGS_SVH

//**********************************************************
// datapath widths
//**********************************************************
`define DEC_XLEN        32   // data and instruction word
`define DEC_GPR_COUNT   32   // architectural registers, x0 included
`define DEC_GPR_ADDR_W  5    // log2 of register count

//**********************************************************
// buffering
//**********************************************************
`define DEC_IB_DEPTH    4    // instruction buffer entries

`endif

// File: common/dec_pkg.sv
`include "dec_settings.svh"

package dec_pkg;

   //**********************************************************
   // instruction formats, one per RV32I encoding
   //**********************************************************
   typedef struct packed {
      logic [6:0] funct7;     // alu op modifier
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm_11_0;  // jalr, loads, alu immediates
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_11_5;   // upper store offset
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;    // lower store offset
      logic [6:0] opcode;
   } s_fmt_t;

   typedef struct packed {
      logic       imm_12;     // sign bit
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;     // sits where rd[0] would be
      logic [6:0] opcode;
   } b_fmt_t;

   typedef struct packed {
      logic [19:0] imm_31_12; // lui / auipc upper bits
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } u_fmt_t;

   typedef struct packed {
      logic       imm_20;     // sign bit
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
   } j_fmt_t;

   // one fetched word, viewed through whichever format the opcode selects
   typedef union packed {
      logic [`DEC_XLEN-1:0] word; // raw bits
      r_fmt_t               r;
      i_fmt_t               i;
      s_fmt_t               s;
      b_fmt_t               b;
      u_fmt_t               u;
      j_fmt_t               j;
   } inst_u;

   //**********************************************************
   // decode result and packets
   //**********************************************************
   typedef enum logic [3:0] {
      LUI,
      AUIPC,
      JAL,
      JALR,
      BRANCH,
      LOAD,
      STORE,
      ALU_IMM,
      ALU_REG,
      ILLEGAL                 // unknown opcode
   } inst_class_e;

   typedef struct packed {
      logic [`DEC_XLEN-1:0] pc;    // fetch address
      inst_u                instr; // fetched word
   } fetch_pkt_t;

   typedef struct packed {
      logic [`DEC_XLEN-1:0]       pc;
      logic [`DEC_XLEN-1:0]       instr;      // raw word, kept for later stages
      inst_class_e                inst_class;
      logic [`DEC_GPR_ADDR_W-1:0] rd;
      logic                       rd_en;      // class writes a register
      logic [`DEC_XLEN-1:0]       rs1_data;
      logic [`DEC_XLEN-1:0]       rs2_data;
      logic [`DEC_XLEN-1:0]       immed;      // sign extended
      logic                       illegal;
   } issue_pkt_t;

   typedef struct packed {
      logic [`DEC_GPR_ADDR_W-1:0] rs1;
      logic [`DEC_GPR_ADDR_W-1:0] rs2;
      logic                       rs1_en;
      logic                       rs2_en;
   } gpr_rd_req_t;

   typedef struct packed {
      logic                       wen;
      logic [`DEC_GPR_ADDR_W-1:0] waddr;
      logic [`DEC_XLEN-1:0]       wdata;
   } gpr_wb_t;

endpackage

// File: src/dec_ib_ctl.sv
`include "dec_settings.svh"

module dec_ib_ctl #(
   parameter int DEPTH = `DEC_IB_DEPTH
) (
   input  logic                clk,
   input  logic                rst_n,

   input  logic                in_valid,   // from fetch
   output logic                in_ready,
   input  dec_pkg::fetch_pkt_t in_pkt,

   output logic                out_valid,  // head valid
   input  logic                out_ready,  // decoder pops
   output dec_pkg::fetch_pkt_t out_pkt
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   dec_pkg::fetch_pkt_t mem [DEPTH];   // entry storage, no reset

   logic [PTR_W-1:0] wr_ptr_q;         // next free slot
   logic [PTR_W-1:0] rd_ptr_q;         // head slot
   logic [CNT_W-1:0] count_q;          // entries held

   logic             full;
   logic             push;
   logic             pop;

   //**********************************************************
   // handshake
   //**********************************************************
   assign full      = (count_q == CNT_W'(DEPTH));
   assign out_valid = (count_q != '0);
   assign in_ready  = !full || out_ready;  // full + pop frees a slot this cycle
   assign push      = in_valid && in_ready;
   assign pop       = out_valid && out_ready;
   assign out_pkt   = mem[rd_ptr_q];

   // payload write, no reset needed
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr_q] <= in_pkt;
      end
   end

   // pointers and occupancy
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1; // wrap
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;         // idle, or push+pop
         endcase
      end
   end

   //**********************************************************
   // checks
   //**********************************************************
   a_count_bound : assert property (
      @(posedge clk) disable iff (!rst_n)
      count_q <= CNT_W'(DEPTH)
   );

   // fetch side must hold its packet until taken
   a_in_stable : assert property (
      @(posedge clk) disable iff (!rst_n)
      (in_valid && !in_ready) |=> (in_valid && $stable(in_pkt))
   );

endmodule

// File: decode/dec_decode_ctl.sv
`include "dec_settings.svh"

module dec_decode_ctl (
   input  logic                 clk,
   input  logic                 rst_n,

   input  logic                 ib_valid,    // buffer head valid
   output logic                 ib_ready,    // pop head
   input  dec_pkg::fetch_pkt_t  ib_head,

   output dec_pkg::gpr_rd_req_t rd_req,      // to register file
   input  logic [`DEC_XLEN-1:0] rs1_rdata,
   input  logic [`DEC_XLEN-1:0] rs2_rdata,

   output logic                 issue_valid,
   input  logic                 issue_ready,
   output dec_pkg::issue_pkt_t  issue
);

   // RV32I major opcodes
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_JALR   = 7'b1100111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;

   dec_pkg::inst_u       instr;        // head word, all views
   dec_pkg::inst_class_e inst_class;
   logic [`DEC_XLEN-1:0] immed;
   logic                 rd_en;
   logic                 rs1_en;
   logic                 rs2_en;
   dec_pkg::issue_pkt_t  issue_d;      // next issue register value
   logic                 issue_valid_q;
   dec_pkg::issue_pkt_t  issue_q;

   assign instr = ib_head.instr;

   //**********************************************************
   // class and immediate, view picked per opcode
   //**********************************************************
   always_comb begin
      inst_class = dec_pkg::ILLEGAL;
      immed      = '0;                 // illegal gives zero immediate
      case (instr.r.opcode)
         OPC_LUI: begin
            inst_class = dec_pkg::LUI;
            immed      = {instr.u.imm_31_12, 12'b0};
         end
         OPC_AUIPC: begin
            inst_class = dec_pkg::AUIPC;
            immed      = {instr.u.imm_31_12, 12'b0};
         end
         OPC_JAL: begin
            inst_class = dec_pkg::JAL;
            immed      = {{(`DEC_XLEN-21){instr.j.imm_20}}, instr.j.imm_20,
                          instr.j.imm_19_12, instr.j.imm_11, instr.j.imm_10_1, 1'b0};
         end
         OPC_JALR: begin
            inst_class = dec_pkg::JALR;
            immed      = {{(`DEC_XLEN-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
         end
         OPC_BRANCH: begin
            inst_class = dec_pkg::BRANCH;
            immed      = {{(`DEC_XLEN-13){instr.b.imm_12}}, instr.b.imm_12,
                          instr.b.imm_11, instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
         end
         OPC_LOAD: begin
            inst_class = dec_pkg::LOAD;
            immed      = {{(`DEC_XLEN-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
         end
         OPC_STORE: begin
            inst_class = dec_pkg::STORE;
            immed      = {{(`DEC_XLEN-12){instr.s.imm_11_5[6]}},
                          instr.s.imm_11_5, instr.s.imm_4_0};
         end
         OPC_OP_IMM: begin
            inst_class = dec_pkg::ALU_IMM;
            immed      = {{(`DEC_XLEN-12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
         end
         OPC_OP: begin
            inst_class = dec_pkg::ALU_REG; // no immediate
         end
         default: begin
            inst_class = dec_pkg::ILLEGAL;
         end
      endcase
   end

   // register usage per class
   always_comb begin
      rd_en  = 1'b0;
      rs1_en = 1'b0;
      rs2_en = 1'b0;
      case (inst_class)
         dec_pkg::LUI,
         dec_pkg::AUIPC,
         dec_pkg::JAL:     rd_en = 1'b1;           // no sources
         dec_pkg::JALR,
         dec_pkg::LOAD,
         dec_pkg::ALU_IMM: begin
            rd_en  = 1'b1;
            rs1_en = 1'b1;
         end
         dec_pkg::BRANCH,
         dec_pkg::STORE: begin
            rs1_en = 1'b1;                         // compare / base + data
            rs2_en = 1'b1;
         end
         dec_pkg::ALU_REG: begin
            rd_en  = 1'b1;
            rs1_en = 1'b1;
            rs2_en = 1'b1;
         end
         default: ;                                // illegal uses nothing
      endcase
   end

   // read request straight from the head
   assign rd_req.rs1    = instr.r.rs1;
   assign rd_req.rs2    = instr.r.rs2;
   assign rd_req.rs1_en = rs1_en;
   assign rd_req.rs2_en = rs2_en;

   always_comb begin
      issue_d.pc         = ib_head.pc;
      issue_d.instr      = instr.word;
      issue_d.inst_class = inst_class;
      issue_d.rd         = instr.r.rd;
      issue_d.rd_en      = rd_en;
      issue_d.rs1_data   = rs1_rdata;    // already bypassed
      issue_d.rs2_data   = rs2_rdata;
      issue_d.immed      = immed;
      issue_d.illegal    = (inst_class == dec_pkg::ILLEGAL);
   end

   //**********************************************************
   // issue register
   //**********************************************************
   assign ib_ready = !issue_valid_q || issue_ready;  // empty or draining

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         issue_valid_q <= 1'b0;
      end else if (ib_ready) begin
         issue_valid_q <= ib_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (ib_valid && ib_ready) begin
         issue_q <= issue_d;               // payload, no reset
      end
   end

   assign issue_valid = issue_valid_q;
   assign issue       = issue_q;

   // stalled packet must not move
   a_issue_stable : assert property (
      @(posedge clk) disable iff (!rst_n)
      (issue_valid && !issue_ready) |=> (issue_valid && $stable(issue))
   );

endmodule

// File: src/dec_gpr_ctl.sv
`include "dec_settings.svh"

module dec_gpr_ctl (
   input  logic                 clk,
   input  logic                 rst_n,
   input  dec_pkg::gpr_rd_req_t rd_req,     // from decode
   output logic [`DEC_XLEN-1:0] rs1_rdata,
   output logic [`DEC_XLEN-1:0] rs2_rdata,
   input  dec_pkg::gpr_wb_t     wb          // single write port
);

   logic [`DEC_XLEN-1:0] gpr_q [1:`DEC_GPR_COUNT-1]; // x0 not stored

   // one read port: x0 / disabled -> 0, same-cycle write wins
   function automatic logic [`DEC_XLEN-1:0] read_port(
      input logic                       en,
      input logic [`DEC_GPR_ADDR_W-1:0] addr
   );
      logic [`DEC_XLEN-1:0] val;
      if (!en || (addr == '0)) begin
         val = '0;
      end else if (wb.wen && (wb.waddr == addr)) begin
         val = wb.wdata;                // write-through bypass
      end else begin
         val = gpr_q[addr];
      end
      return val;
   endfunction

   //**********************************************************
   // storage
   //**********************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int k = 1; k < `DEC_GPR_COUNT; k++) begin
            gpr_q[k] <= '0;             // all regs read zero after reset
         end
      end else if (wb.wen && (wb.waddr != '0)) begin
         gpr_q[wb.waddr] <= wb.wdata;   // x0 writes dropped
      end
   end

   // read ports
   always_comb begin
      rs1_rdata = read_port(rd_req.rs1_en, rd_req.rs1);
      rs2_rdata = read_port(rd_req.rs2_en, rd_req.rs2);
   end

   // writer outside must present clean data
   a_wdata_known : assert property (
      @(posedge clk) disable iff (!rst_n)
      wb.wen |-> !$isunknown({wb.waddr, wb.wdata})
   );

endmodule

// File: src/dec.sv
`include "dec_settings.svh"

module dec (
   input  logic                clk,
   input  logic                rst_n,          // async, active low

   // fetch side
   input  logic                fetch_valid,
   output logic                fetch_ready,    // low only when buffer full
   input  dec_pkg::fetch_pkt_t fetch,

   // issue side
   output logic                issue_valid,
   input  logic                issue_ready,
   output dec_pkg::issue_pkt_t issue,

   // writeback, always accepted
   input  dec_pkg::gpr_wb_t    wb
);

   //**********************************************************
   // internal wires
   //**********************************************************
   logic                 ib_valid;   // buffer head present
   logic                 ib_ready;   // decoder can take head
   dec_pkg::fetch_pkt_t  ib_head;

   dec_pkg::gpr_rd_req_t rd_req;     // read addresses from head
   logic [`DEC_XLEN-1:0] rs1_rdata;  // bypassed read data
   logic [`DEC_XLEN-1:0] rs2_rdata;

   // instruction buffer, fetch -> decode
   dec_ib_ctl #(
      .DEPTH     (`DEC_IB_DEPTH)
   ) ib_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (fetch_valid),
      .in_ready  (fetch_ready),
      .in_pkt    (fetch),
      .out_valid (ib_valid),
      .out_ready (ib_ready),
      .out_pkt   (ib_head)
   );

   // format decode and issue register
   dec_decode_ctl decode_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .ib_valid    (ib_valid),
      .ib_ready    (ib_ready),
      .ib_head     (ib_head),
      .rd_req      (rd_req),
      .rs1_rdata   (rs1_rdata),
      .rs2_rdata   (rs2_rdata),
      .issue_valid (issue_valid),
      .issue_ready (issue_ready),
      .issue       (issue)
   );

   // architectural register file, read at decode
   dec_gpr_ctl gpr_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .rd_req    (rd_req),
      .rs1_rdata (rs1_rdata),
      .rs2_rdata (rs2_rdata),
      .wb        (wb)        // straight from outside
   );

endmodule

// File: testbench/dec_tb_vectors.svh
`ifndef DEC_TB_VECTORS_SVH
`define DEC_TB_VECTORS_SVH

//**********************************************************
// stimulus table
//**********************************************************
localparam logic [1:0] K_WR = 2'd0;  // register write only
localparam logic [1:0] K_IN = 2'd1;  // instruction, normal flow
localparam logic [1:0] K_BP = 2'd2;  // instruction, write lands one cycle after accept

typedef struct packed {
   logic [1:0]                 kind;
   logic [`DEC_XLEN-1:0]       word;     // instruction word
   logic [`DEC_GPR_ADDR_W-1:0] waddr;    // K_WR / K_BP only
   logic [`DEC_XLEN-1:0]       wdata;
   dec_pkg::inst_class_e       cls;      // expected decode from here on
   logic [`DEC_GPR_ADDR_W-1:0] rd;       // bits 11:7 of the word
   logic                       rd_en;
   logic [`DEC_XLEN-1:0]       immed;    // sign extended
   logic                       illegal;
   logic [`DEC_GPR_ADDR_W-1:0] rs1_idx;  // shadow index for rs1_data, 0 gives zero
   logic [`DEC_GPR_ADDR_W-1:0] rs2_idx;
} vec_t;

localparam int N_VEC = 21;

// kind  word          waddr wdata          class              rd en immed       ill rs1 rs2
localparam vec_t VECS [N_VEC] = '{
   '{K_IN, 32'h002081b3, 0, 32'h00000000, dec_pkg::ALU_REG, 3,  1, 32'h00000000, 0, 1, 2},
   '{K_WR, 32'h00000000, 1, 32'h12345678, dec_pkg::ILLEGAL, 0,  0, 32'h00000000, 0, 0, 0},
   '{K_WR, 32'h00000000, 2, 32'hdeadbeef, dec_pkg::ILLEGAL, 0,  0, 32'h00000000, 0, 0, 0},
   '{K_WR, 32'h00000000, 0, 32'h5555aaaa, dec_pkg::ILLEGAL, 0,  0, 32'h00000000, 0, 0, 0},
   '{K_IN, 32'h00208233, 0, 32'h00000000, dec_pkg::ALU_REG, 4,  1, 32'h00000000, 0, 1, 2},
   '{K_IN, 32'hfff00313, 0, 32'h00000000, dec_pkg::ALU_IMM, 6,  1, 32'hffffffff, 0, 0, 0},
   '{K_IN, 32'h002003b3, 0, 32'h00000000, dec_pkg::ALU_REG, 7,  1, 32'h00000000, 0, 0, 2},
   '{K_IN, 32'habcde437, 0, 32'h00000000, dec_pkg::LUI,     8,  1, 32'habcde000, 0, 0, 0},
   '{K_IN, 32'h00012497, 0, 32'h00000000, dec_pkg::AUIPC,   9,  1, 32'h00012000, 0, 0, 0},
   '{K_IN, 32'hff9ff0ef, 0, 32'h00000000, dec_pkg::JAL,     1,  1, 32'hfffffff8, 0, 0, 0},
   '{K_IN, 32'hffc10567, 0, 32'h00000000, dec_pkg::JALR,    10, 1, 32'hfffffffc, 0, 2, 0},
   '{K_IN, 32'hfe2088e3, 0, 32'h00000000, dec_pkg::BRANCH,  17, 0, 32'hfffffff0, 0, 1, 2},
   '{K_IN, 32'hfec0a583, 0, 32'h00000000, dec_pkg::LOAD,    11, 1, 32'hffffffec, 0, 1, 0},
   '{K_IN, 32'hfc20ae23, 0, 32'h00000000, dec_pkg::STORE,   28, 0, 32'hffffffdc, 0, 1, 2},
   '{K_IN, 32'hffffffff, 0, 32'h00000000, dec_pkg::ILLEGAL, 31, 0, 32'h00000000, 1, 0, 0},
   '{K_IN, 32'h7ff10613, 0, 32'h00000000, dec_pkg::ALU_IMM, 12, 1, 32'h000007ff, 0, 2, 0},
   '{K_IN, 32'h00000000, 0, 32'h00000000, dec_pkg::ILLEGAL, 0,  0, 32'h00000000, 1, 0, 0},
   '{K_IN, 32'h00111463, 0, 32'h00000000, dec_pkg::BRANCH,  8,  0, 32'h00000008, 0, 2, 1},
   '{K_BP, 32'h001286b3, 5, 32'h0badf00d, dec_pkg::ALU_REG, 13, 1, 32'h00000000, 0, 5, 1},
   '{K_BP, 32'h00108713, 1, 32'hcafe0001, dec_pkg::ALU_IMM, 14, 1, 32'h00000001, 0, 1, 0},
   '{K_BP, 32'h000007b3, 0, 32'hffffffff, dec_pkg::ALU_REG, 15, 1, 32'h00000000, 0, 0, 0}
};

`endif

// File: testbench/dec_tb.sv
`include "dec_settings.svh"

module dec_tb;

   `include "dec_tb_vectors.svh"

   localparam int N_PASS         = 2;                     // steady flow, then random stalls
   localparam int TIMEOUT_CYCLES = 20 * N_VEC * N_PASS + 100;

   logic                clk;
   logic                rst_n;
   logic                fetch_valid;
   logic                fetch_ready;
   dec_pkg::fetch_pkt_t fetch;
   logic                issue_valid;
   logic                issue_ready;
   dec_pkg::issue_pkt_t issue;
   dec_pkg::gpr_wb_t    wb;

   logic [`DEC_XLEN-1:0] shadow [`DEC_GPR_COUNT];  // expected register contents
   dec_pkg::issue_pkt_t  exp_q [$];                // in-order expected packets
   logic [`DEC_XLEN-1:0] next_pc;
   logic                 rand_mode;                // random stalls and gaps on
   logic                 gap_bit;                  // fetch idles this cycle
   logic [31:0]          lfsr_q;
   int                   cycles;
   int                   accepted;                 // fetch transfers
   int                   issued;                   // issue transfers

   dec dec_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .fetch_valid (fetch_valid),
      .fetch_ready (fetch_ready),
      .fetch       (fetch),
      .issue_valid (issue_valid),
      .issue_ready (issue_ready),
      .issue       (issue),
      .wb          (wb)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //**********************************************************
   // helpers
   //**********************************************************
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);   // galois, x^32+x^22+x^2+x+1
   endfunction

   task automatic stop_on_error(input string line);
      $display("%s", line);
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_true(input bit ok, input string what);
      assert (ok) else begin
         stop_on_error($sformatf("CHECK FAILED at time %0t: %s", $time, what));
      end
   endtask

   function automatic dec_pkg::issue_pkt_t expect_pkt(input vec_t v, input logic [31:0] pc);
      dec_pkg::issue_pkt_t p;
      p.pc         = pc;
      p.instr      = v.word;
      p.inst_class = v.cls;
      p.rd         = v.rd;
      p.rd_en      = v.rd_en;
      p.rs1_data   = shadow[v.rs1_idx];   // x0 entry stays zero
      p.rs2_data   = shadow[v.rs2_idx];
      p.immed      = v.immed;
      p.illegal    = v.illegal;
      return p;
   endfunction

   task automatic drain();
      while (exp_q.size() != 0) begin   // all sent instructions issued
         @(posedge clk);
         #10;
      end
   endtask

   task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
      wb.wen   = 1'b1;
      wb.waddr = addr;
      wb.wdata = data;
      @(posedge clk);
      #10;
      wb.wen = 1'b0;
      if (addr != '0) begin
         shadow[addr] = data;           // x0 never changes
      end
   endtask

   task automatic send_instr(input vec_t v);
      logic taken;
      while (rand_mode && gap_bit) begin   // random fetch bubbles
         @(posedge clk);
         #10;
      end
      exp_q.push_back(expect_pkt(v, next_pc));
      fetch_valid = 1'b1;
      fetch.pc    = next_pc;
      fetch.instr = v.word;
      next_pc     = next_pc + 4;
      taken       = 1'b0;
      while (!taken) begin
         @(posedge clk);
         taken = fetch_ready;           // held until transfer
         #10;
      end
      fetch_valid = 1'b0;
   endtask

   // accept at edge N, write in the N..N+1 cycle, issue after N+1
   task automatic bypass_instr(input vec_t v);
      logic keep_mode;
      keep_mode = rand_mode;
      drain();
      rand_mode = 1'b0;
      repeat (2) begin                  // let issue_ready settle high
         @(posedge clk);
         #10;
      end
      if (v.waddr != '0) begin
         shadow[v.waddr] = v.wdata;
      end
      exp_q.push_back(expect_pkt(v, next_pc));
      fetch_valid = 1'b1;
      fetch.pc    = next_pc;
      fetch.instr = v.word;
      next_pc     = next_pc + 4;
      @(posedge clk);                   // edge N
      check_true(fetch_ready, "fetch_ready low with empty buffer");
      #10;
      fetch_valid = 1'b0;
      wb.wen      = 1'b1;
      wb.waddr    = v.waddr;
      wb.wdata    = v.wdata;
      @(posedge clk);                   // edge N+1
      #10;
      wb.wen = 1'b0;
      check_true(issue_valid, "instruction not on issue one cycle after acceptance");
      rand_mode = keep_mode;
   endtask

   task automatic apply_vector(input vec_t v);
      case (v.kind)
         K_WR: begin
            drain();                    // no read in flight during a write
            write_reg(v.waddr, v.wdata);
         end
         K_IN:    send_instr(v);
         default: bypass_instr(v);
      endcase
   endtask

   //**********************************************************
   // monitor, issue_ready pacing, timeout
   //**********************************************************
   initial begin
      dec_pkg::issue_pkt_t exp_pkt;
      dec_pkg::issue_pkt_t held_pkt;
      logic                stall_q;
      logic                ready_next;
      logic                bit_a;
      logic                bit_b;
      cycles   = 0;
      accepted = 0;
      issued   = 0;
      stall_q  = 1'b0;
      lfsr_q   = 32'he8d;
      gap_bit  = 1'b0;
      held_pkt = '0;
      forever begin
         @(posedge clk);
         cycles++;
         if (cycles > TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("timeout: run not finished after %0d cycles", cycles));
         end
         if (rst_n) begin
            if (stall_q) begin
               check_true(issue_valid && (issue === held_pkt), "issue packet moved while stalled");
            end
            if (!fetch_ready) begin                       // buffer must really be full
               check_true(accepted - issued - int'(issue_valid) == `DEC_IB_DEPTH,
                          "fetch_ready low while buffer not full");
            end
            if (issue_valid && issue_ready) begin
               check_true(exp_q.size() != 0, "issue transfer with nothing outstanding");
               exp_pkt = exp_q.pop_front();
               check_true(issue === exp_pkt,
                          $sformatf("issue %p, expected %p", issue, exp_pkt));
               issued++;
            end
            if (fetch_valid && fetch_ready) begin
               accepted++;
            end
            stall_q  = issue_valid && !issue_ready;
            held_pkt = issue;
         end
         lfsr_q  = lfsr_next(lfsr_q);
         bit_a   = lfsr_q[0];
         lfsr_q  = lfsr_next(lfsr_q);
         bit_b   = lfsr_q[0];
         lfsr_q  = lfsr_next(lfsr_q);
         gap_bit = lfsr_q[0];
         ready_next = rand_mode ? (bit_a & bit_b) : 1'b1;  // ready 1 in 4 when random
         #10;
         issue_ready = ready_next;
      end
   end

   //**********************************************************
   // main sequence
   //**********************************************************
   initial begin
      rst_n       = 1'b0;
      fetch_valid = 1'b0;
      fetch       = '0;
      issue_ready = 1'b0;
      wb          = '0;
      rand_mode   = 1'b0;
      next_pc     = 32'h0000_1000;
      for (int k = 0; k < `DEC_GPR_COUNT; k++) begin
         shadow[k] = '0;
      end
      repeat (4) @(posedge clk);
      #10;
      rst_n = 1'b1;
      check_true(!issue_valid, "issue_valid high after reset");
      check_true(fetch_ready, "fetch_ready low after reset");
      for (int pass = 0; pass < N_PASS; pass++) begin
         rand_mode = (pass == 1);
         for (int k = 0; k < N_VEC; k++) begin
            apply_vector(VECS[k]);
         end
      end
      drain();
      if (!issue_valid) begin                // nothing left once the last packet is taken
         $display("*** PASSED ***");
         $finish;
      end else begin
         stop_on_error("issue_valid still high after the last expected packet");
      end
   end

endmodule

// File: sources.f
+incdir+common
+incdir+testbench
common/dec_pkg.sv
src/dec_ib_ctl.sv
decode/dec_decode_ctl.sv
src/dec_gpr_ctl.sv
src/dec.sv
testbench/dec_tb.sv

// File: Bender.yml
package:
  name: dec

sources:
  - include_dirs:
      - common
    files:
      - common/dec_pkg.sv
      - src/dec_ib_ctl.sv
      - decode/dec_decode_ctl.sv
      - src/dec_gpr_ctl.sv
      - src/dec.sv

  - target: test
    include_dirs:
      - common
      - testbench
    files:
      - testbench/dec_tb.sv
